// File: sim.f
verilog/mem_stage_pkg.sv
verilog/dmem_if.sv
verilog/mem_decode.sv
verilog/data_memory.sv
verilog/dump_sequencer.sv
verilog/dump_counter.sv
verilog/xm_pipe_reg.sv
verilog/memory_stage.sv
bench/memory_stage_chk.sv
bench/memory_stage_tb.sv

// File: Makefile
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= memory_stage_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
# Keep running past an assertion so the testbench reports it
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/memory_stage_tb.sv
// Memory stage testbench with clock, reset, random stimulus, dump runs and watchdog
module memory_stage_tb;

   localparam int addr_bits    = 4;
   localparam int depth        = 2 ** addr_bits;
   localparam int reset_cycles = 8;
   localparam int store_cycles = 64;
   localparam int mixed_cycles = 256;
   localparam int extra_stores = 8;
   // Dump walk bound with stalls on about one cycle in four
   localparam int dump_limit   = 8 * depth;
   localparam int total_cycles = reset_cycles + store_cycles + mixed_cycles + depth +
                                 extra_stores + 2 * (dump_limit + 2) + 8;
   // Twice the phase length in time units
   localparam int watchdog_time = total_cycles * 20 * 2;

   logic                    clk = 1'b0;
   logic                    reset;
   mem_stage_pkg::word_t    instruction_in;
   mem_stage_pkg::word_t    incr_pc;
   mem_stage_pkg::word_t    b_input;
   mem_stage_pkg::word_t    x_comp;
   mem_stage_pkg::word_t    rt_in;
   mem_stage_pkg::word_t    address;
   logic                    reg_wrt_in;
   logic                    wb_reg_wrt;
   mem_stage_pkg::reg_idx_t wb_rd;
   mem_stage_pkg::word_t    wb_rd_data;
   logic                    dump;
   logic                    dump_ready;
   mem_stage_pkg::word_t    instruction_out;
   mem_stage_pkg::word_t    incr_pc_out;
   mem_stage_pkg::word_t    b_input_out;
   mem_stage_pkg::word_t    x_comp_out;
   mem_stage_pkg::word_t    read_data_out;
   logic                    reg_wrt_out;
   mem_stage_pkg::reg_idx_t xm_rd;
   logic                    dump_valid;
   mem_stage_pkg::word_t    dump_data;
   logic                    dump_done;
   logic [31:0]             lcg_state = 32'd13410;

   // 20 unit clock
   always #10 clk = ~clk;

   memory_stage #(.addr_bits(addr_bits)) u_dut (.*);

   // Shadow memory and assertions ride along inside the DUT
   bind memory_stage memory_stage_chk #(.addr_bits(addr_bits)) u_chk (.*);

   //////////////////////////////
   // Random sources
   //////////////////////////////

   function automatic mem_stage_pkg::word_t next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      // Upper half, better period than the low bits
      return lcg_state[31:16];
   endfunction

   function automatic mem_stage_pkg::opcode_t pick_opcode();
      mem_stage_pkg::word_t r;
      r = next_random();
      case (r[2:0])
         3'd0: return mem_stage_pkg::op_st;
         3'd1: return mem_stage_pkg::op_ld;
         3'd2: return mem_stage_pkg::op_slbi;
         3'd3: return mem_stage_pkg::op_stu;
         3'd4: return mem_stage_pkg::op_lbi;
         3'd5: return mem_stage_pkg::op_jal;
         3'd6: return mem_stage_pkg::op_jalr;
         default: return r[15:11];
      endcase
   endfunction

   //////////////////////////////
   // Drivers
   //////////////////////////////

   // One instruction slot, fields random apart from the opcode
   task automatic drive_instr(input mem_stage_pkg::opcode_t op);
      mem_stage_pkg::word_t ctl;
      mem_stage_pkg::word_t low;
      @(posedge clk);
      #2;
      ctl            = next_random();
      low            = next_random();
      instruction_in = {op, low[10:0]};
      incr_pc        = next_random();
      b_input        = next_random();
      x_comp         = next_random();
      rt_in          = next_random();
      address        = next_random();
      reg_wrt_in     = ctl[0];
      wb_reg_wrt     = ctl[1];
      // Half the time writeback targets the store source register
      wb_rd          = ctl[2] ? instruction_in[7:5] : ctl[5:3];
      wb_rd_data     = next_random();
   endtask

   // Full dump with random stalls and a restart pulse mid walk
   task automatic run_dump();
      mem_stage_pkg::word_t ready_bits;
      int                   walk_cycles;
      drive_instr(mem_stage_pkg::op_slbi);
      dump        = 1'b1;
      walk_cycles = 0;
      do begin
         drive_instr(walk_cycles[0] ? mem_stage_pkg::op_ld : mem_stage_pkg::op_jal);
         ready_bits = next_random();
         dump_ready = (ready_bits[1:0] != 2'b00);
         // Ignored, the walk is already running
         dump       = (walk_cycles == 5);
         walk_cycles++;
         if (walk_cycles > dump_limit) begin
            $display("Simulation failed");
            $fatal(1, "dump_done did not arrive within %0d cycles", dump_limit);
         end
      end while (!dump_done);
      dump       = 1'b0;
      dump_ready = 1'b0;
   endtask

   //////////////////////////////
   // Sequence
   //////////////////////////////

   initial begin
      mem_stage_pkg::word_t sel;
      reset          = 1'b1;
      instruction_in = '0;
      incr_pc        = '0;
      b_input        = '0;
      x_comp         = '0;
      rt_in          = '0;
      address        = '0;
      reg_wrt_in     = 1'b0;
      wb_reg_wrt     = 1'b0;
      wb_rd          = '0;
      wb_rd_data     = '0;
      dump           = 1'b0;
      dump_ready     = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #2;
      reset = 1'b0;
      // Fill memory with forwarded and plain stores
      repeat (store_cycles) begin
         sel = next_random();
         drive_instr(sel[0] ? mem_stage_pkg::op_st : mem_stage_pkg::op_stu);
      end
      // Loads, stores and non-memory opcodes mixed
      repeat (mixed_cycles) begin
         drive_instr(pick_opcode());
      end
      // Read back every word in order
      for (int i = 0; i < depth; i++) begin
         drive_instr(mem_stage_pkg::op_ld);
         address = mem_stage_pkg::word_t'(i);
      end
      run_dump();
      repeat (extra_stores) begin
         drive_instr(mem_stage_pkg::op_st);
      end
      run_dump();
      repeat (3) begin
         drive_instr(mem_stage_pkg::op_slbi);
      end
      @(negedge clk);
      if (u_dut.u_chk.failed) begin
         $display("Simulation failed");
         $fatal(1, "checker assertion failed near the end of the run");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

   // First assertion failure ends the run
   always @(negedge clk) begin
      if (u_dut.u_chk.failed) begin
         $display("Simulation failed");
         $fatal(1, "checker assertion failed");
      end
   end

   // Hang guard
   initial begin
      #(watchdog_time);
      $display("Simulation failed");
      $fatal(1, "watchdog expired before the stimulus finished");
   end

endmodule

// File: bench/memory_stage_chk.sv
// Memory stage checker with shadow data memory, output models and concurrent assertions
module memory_stage_chk #(
   parameter int addr_bits = 8
) (
   input logic                    clk,
   input logic                    reset,
   input mem_stage_pkg::word_t    instruction_in,
   input mem_stage_pkg::word_t    incr_pc,
   input mem_stage_pkg::word_t    b_input,
   input mem_stage_pkg::word_t    x_comp,
   input mem_stage_pkg::word_t    rt_in,
   input mem_stage_pkg::word_t    address,
   input logic                    reg_wrt_in,
   input logic                    wb_reg_wrt,
   input mem_stage_pkg::reg_idx_t wb_rd,
   input mem_stage_pkg::word_t    wb_rd_data,
   input logic                    dump,
   input logic                    dump_ready,
   input mem_stage_pkg::word_t    instruction_out,
   input mem_stage_pkg::word_t    incr_pc_out,
   input mem_stage_pkg::word_t    b_input_out,
   input mem_stage_pkg::word_t    x_comp_out,
   input mem_stage_pkg::word_t    read_data_out,
   input logic                    reg_wrt_out,
   input mem_stage_pkg::reg_idx_t xm_rd,
   input logic                    dump_valid,
   input mem_stage_pkg::word_t    dump_data,
   input logic                    dump_done
);

   localparam int depth = 2 ** addr_bits;

   mem_stage_pkg::word_t    shadow [depth];
   logic [64:0]             exp_pass;
   logic [64:0]             got_pass;
   mem_stage_pkg::word_t    exp_read;
   mem_stage_pkg::reg_idx_t exp_rd;
   logic                    exp_valid;
   logic                    exp_done;
   logic [addr_bits-1:0]    dump_idx;
   mem_stage_pkg::word_t    dump_exp;
   mem_stage_pkg::opcode_t  opcode;
   logic [addr_bits-1:0]    word_sel;
   logic                    is_store;
   mem_stage_pkg::word_t    store_data;
   // Raised by any failing assertion, polled by the testbench
   logic                    failed = 1'b0;

   assign opcode   = instruction_in[15:11];
   assign word_sel = address[addr_bits-1:0];
   assign is_store = (opcode == mem_stage_pkg::op_st) || (opcode == mem_stage_pkg::op_stu);
   // Writeback value replaces rt when its register is the store source
   assign store_data = (wb_reg_wrt && (wb_rd == instruction_in[7:5])) ? wb_rd_data : rt_in;
   assign got_pass   = {instruction_out, incr_pc_out, b_input_out, x_comp_out, reg_wrt_out};
   assign dump_exp   = shadow[dump_idx];

   // Destination index by opcode class
   function automatic mem_stage_pkg::reg_idx_t dest_of(input mem_stage_pkg::word_t instr);
      casez (instr[15:11])
         mem_stage_pkg::op_slbi, mem_stage_pkg::op_lbi, mem_stage_pkg::op_stu: begin
            return instr[10:8];
         end
         mem_stage_pkg::op_jal, mem_stage_pkg::op_jalr: begin
            return 3'd7;
         end
         5'b11???: begin
            return instr[4:2];
         end
         default: begin
            return instr[7:5];
         end
      endcase
   endfunction

   //////////////////////////////
   // Reference model
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < depth; i++) begin
            shadow[i] <= '0;
         end
         exp_pass  <= '0;
         exp_read  <= '0;
         exp_rd    <= '0;
         exp_valid <= 1'b0;
         exp_done  <= 1'b0;
         dump_idx  <= '0;
      end else begin
         if (is_store) begin
            shadow[word_sel] <= store_data;
         end
         exp_pass <= {instruction_in, incr_pc, b_input, x_comp, reg_wrt_in};
         // Old contents, a load is never a store
         exp_read <= (opcode == mem_stage_pkg::op_ld) ? shadow[word_sel] : '0;
         exp_rd   <= dest_of(instruction_in);
         // Walk ends on acceptance of the top word
         if (exp_valid) begin
            exp_valid <= !(dump_ready && (&dump_idx));
         end else begin
            // Start only from idle, the done cycle is not idle
            exp_valid <= dump && !exp_done;
         end
         exp_done <= exp_valid && dump_ready && (&dump_idx);
         if (!exp_valid) begin
            dump_idx <= '0;
         end else if (dump_ready) begin
            dump_idx <= dump_idx + 1'b1;
         end
      end
   end

   //////////////////////////////
   // Assertions
   //////////////////////////////

   a_pass: assert property (@(posedge clk) disable iff (reset) got_pass == exp_pass)
      else begin
         failed = 1'b1;
         $error("FAILED %0t instruction_out/incr_pc_out/b_input_out/x_comp_out/reg_wrt_out",
            $time, " exp %h got %h", $sampled(exp_pass), $sampled(got_pass));
      end

   a_read: assert property (@(posedge clk) disable iff (reset) read_data_out == exp_read)
      else begin
         failed = 1'b1;
         $error("FAILED %0t read_data_out exp %h got %h", $time,
            $sampled(exp_read), $sampled(read_data_out));
      end

   a_rd: assert property (@(posedge clk) disable iff (reset) xm_rd == exp_rd)
      else begin
         failed = 1'b1;
         $error("FAILED %0t xm_rd exp %0d got %0d", $time, $sampled(exp_rd), $sampled(xm_rd));
      end

   a_valid: assert property (@(posedge clk) disable iff (reset) dump_valid == exp_valid)
      else begin
         failed = 1'b1;
         $error("FAILED %0t dump_valid exp %b got %b", $time,
            $sampled(exp_valid), $sampled(dump_valid));
      end

   // Word order and stall hold both follow from the tracked index
   a_data: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> dump_data == dump_exp)
      else begin
         failed = 1'b1;
         $error("FAILED %0t dump_data exp %h got %h", $time,
            $sampled(dump_exp), $sampled(dump_data));
      end

   a_done: assert property (@(posedge clk) disable iff (reset) dump_done == exp_done)
      else begin
         failed = 1'b1;
         $error("FAILED %0t dump_done exp %b got %b", $time,
            $sampled(exp_done), $sampled(dump_done));
      end

endmodule

// File: verilog/memory_stage.sv
// Memory stage top with decoder, data memory, pipeline register and dump logic
module memory_stage #(
   parameter int addr_bits = 8
) (
   input  logic                    clk,
   input  logic                    reset,
   input  mem_stage_pkg::word_t    instruction_in,
   input  mem_stage_pkg::word_t    incr_pc,
   input  mem_stage_pkg::word_t    b_input,
   input  mem_stage_pkg::word_t    x_comp,
   input  mem_stage_pkg::word_t    rt_in,
   input  mem_stage_pkg::word_t    address,
   input  logic                    reg_wrt_in,
   input  logic                    wb_reg_wrt,
   input  mem_stage_pkg::reg_idx_t wb_rd,
   input  mem_stage_pkg::word_t    wb_rd_data,
   input  logic                    dump,
   input  logic                    dump_ready,
   output mem_stage_pkg::word_t    instruction_out,
   output mem_stage_pkg::word_t    incr_pc_out,
   output mem_stage_pkg::word_t    b_input_out,
   output mem_stage_pkg::word_t    x_comp_out,
   output mem_stage_pkg::word_t    read_data_out,
   output logic                    reg_wrt_out,
   output mem_stage_pkg::reg_idx_t xm_rd,
   output logic                    dump_valid,
   output mem_stage_pkg::word_t    dump_data,
   output logic                    dump_done
);

   mem_stage_pkg::reg_idx_t dest_rd;
   mem_stage_pkg::word_t    read_data;
   mem_stage_pkg::word_t    dump_addr;
   logic                    count_clear;
   logic                    count_advance;
   logic                    last_addr;

   dmem_if #(.addr_bits(addr_bits)) dmem_bus ();

   ////////////////////////////////
   // Access path
   ////////////////////////////////

   mem_decode u_decode (
      .instruction (instruction_in),
      .address     (address),
      .rt_in       (rt_in),
      .wb_reg_wrt  (wb_reg_wrt),
      .wb_rd       (wb_rd),
      .wb_rd_data  (wb_rd_data),
      .dmem        (dmem_bus.decoder),
      .dest_rd     (dest_rd),
      .read_data   (read_data)
   );

   // Dump port reads alongside normal accesses
   data_memory #(.addr_bits(addr_bits)) u_memory (
      .clk       (clk),
      .reset     (reset),
      .dmem      (dmem_bus.memory),
      .dump_addr (dump_addr),
      .dump_word (dump_data)
   );

   xm_pipe_reg u_pipe (
      .clk             (clk),
      .reset           (reset),
      .instruction     (instruction_in),
      .incr_pc         (incr_pc),
      .b_input         (b_input),
      .x_comp          (x_comp),
      .read_data       (read_data),
      .reg_wrt         (reg_wrt_in),
      .dest_rd         (dest_rd),
      .instruction_out (instruction_out),
      .incr_pc_out     (incr_pc_out),
      .b_input_out     (b_input_out),
      .x_comp_out      (x_comp_out),
      .read_data_out   (read_data_out),
      .reg_wrt_out     (reg_wrt_out),
      .xm_rd           (xm_rd)
   );

   ////////////////////////////////
   // Dump path
   ////////////////////////////////

   dump_sequencer u_dump_seq (
      .clk           (clk),
      .reset         (reset),
      .dump          (dump),
      .dump_ready    (dump_ready),
      .last_addr     (last_addr),
      .count_clear   (count_clear),
      .count_advance (count_advance),
      .dump_valid    (dump_valid),
      .dump_done     (dump_done)
   );

   dump_counter #(.addr_bits(addr_bits)) u_dump_cnt (
      .clk           (clk),
      .reset         (reset),
      .count_clear   (count_clear),
      .count_advance (count_advance),
      .dump_addr     (dump_addr),
      .last_addr     (last_addr)
   );

endmodule

// File: verilog/xm_pipe_reg.sv
// Memory to writeback pipeline register for instruction, PC, operands and results
module xm_pipe_reg (
   input  logic                    clk,
   input  logic                    reset,
   input  mem_stage_pkg::word_t    instruction,
   input  mem_stage_pkg::word_t    incr_pc,
   input  mem_stage_pkg::word_t    b_input,
   input  mem_stage_pkg::word_t    x_comp,
   input  mem_stage_pkg::word_t    read_data,
   input  logic                    reg_wrt,
   input  mem_stage_pkg::reg_idx_t dest_rd,
   output mem_stage_pkg::word_t    instruction_out,
   output mem_stage_pkg::word_t    incr_pc_out,
   output mem_stage_pkg::word_t    b_input_out,
   output mem_stage_pkg::word_t    x_comp_out,
   output mem_stage_pkg::word_t    read_data_out,
   output logic                    reg_wrt_out,
   output mem_stage_pkg::reg_idx_t xm_rd
);

   // One cycle slot, no stall
   always_ff @(posedge clk) begin
      if (reset) begin
         instruction_out <= '0;
         incr_pc_out     <= '0;
         b_input_out     <= '0;
         x_comp_out      <= '0;
         read_data_out   <= '0;
         reg_wrt_out     <= 1'b0;
         xm_rd           <= '0;
      end else begin
         instruction_out <= instruction;
         incr_pc_out     <= incr_pc;
         b_input_out     <= b_input;
         x_comp_out      <= x_comp;
         read_data_out   <= read_data;
         reg_wrt_out     <= reg_wrt;
         xm_rd           <= dest_rd;
      end
   end

endmodule

// File: verilog/dump_counter.sv
// Dump address counter with clear, advance and last word flag
module dump_counter #(
   parameter int addr_bits = 8
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 count_clear,
   input  logic                 count_advance,
   output mem_stage_pkg::word_t dump_addr,
   output logic                 last_addr
);

   logic [addr_bits-1:0] count;

   // Clear wins over advance, otherwise hold
   always_ff @(posedge clk) begin
      if (reset || count_clear) begin
         count <= '0;
      end else if (count_advance) begin
         count <= count + 1'b1;
      end
   end

   // Zero extended to a full word
   assign dump_addr = mem_stage_pkg::word_t'(count);

   // Top word of memory
   assign last_addr = &count;

endmodule

// File: verilog/dump_sequencer.sv
// Dump state machine driving counter control and the valid/ready dump stream
module dump_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic dump,
   input  logic dump_ready,
   input  logic last_addr,
   output logic count_clear,
   output logic count_advance,
   output logic dump_valid,
   output logic dump_done
);

   mem_stage_pkg::dump_state_t state;
   mem_stage_pkg::dump_state_t state_next;

   ////////////////////////////////
   // State register
   ////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= mem_stage_pkg::idle;
      end else begin
         state <= state_next;
      end
   end

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         mem_stage_pkg::idle: begin
            // Start only from idle, pulses during a walk are dropped
            if (dump) begin
               state_next = mem_stage_pkg::walk;
            end
         end
         mem_stage_pkg::walk: begin
            // Final word accepted
            if (dump_ready && last_addr) begin
               state_next = mem_stage_pkg::finish;
            end
         end
         default: begin
            state_next = mem_stage_pkg::idle;
         end
      endcase
   end

   ////////////////////////////////
   // Outputs
   ////////////////////////////////

   assign dump_valid    = (state == mem_stage_pkg::walk);
   // Counter back to zero alongside the walk entry
   assign count_clear   = (state == mem_stage_pkg::idle) && dump;
   // Step on each accepted word
   assign count_advance = dump_valid && dump_ready;
   // One cycle done flag
   assign dump_done     = (state == mem_stage_pkg::finish);

endmodule

// File: verilog/data_memory.sv
// Word-addressed data memory with gated main read and ungated dump read port
module data_memory #(
   parameter int addr_bits = 8
) (
   input  logic                 clk,
   input  logic                 reset,
   dmem_if.memory               dmem,
   input  mem_stage_pkg::word_t dump_addr,
   output mem_stage_pkg::word_t dump_word
);

   localparam int depth = 2 ** addr_bits;

   // Storage array
   mem_stage_pkg::word_t mem [depth];

   ////////////////////////////////
   // Write port
   ////////////////////////////////

   // Contents cleared on reset, stores land at the edge
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (dmem.enable && dmem.write) begin
         mem[dmem.word_sel] <= dmem.write_data;
      end
   end

   ////////////////////////////////
   // Read ports
   ////////////////////////////////

   // Main read, zero while disabled
   assign dmem.read_data = dmem.enable ? mem[dmem.word_sel] : '0;

   // Dump read always live, low bits select
   assign dump_word = mem[dump_addr[addr_bits-1:0]];

endmodule

// File: verilog/mem_decode.sv
// Memory control decode, store data forwarding and destination register parsing
module mem_decode (
   input  mem_stage_pkg::word_t    instruction,
   input  mem_stage_pkg::word_t    address,
   input  mem_stage_pkg::word_t    rt_in,
   input  logic                    wb_reg_wrt,
   input  mem_stage_pkg::reg_idx_t wb_rd,
   input  mem_stage_pkg::word_t    wb_rd_data,
   dmem_if.decoder                 dmem,
   output mem_stage_pkg::reg_idx_t dest_rd,
   output mem_stage_pkg::word_t    read_data
);

   mem_stage_pkg::opcode_t opcode;
   logic                   fwd_hit;

   assign opcode = instruction[15:11];

   ////////////////////////////////
   // Memory control
   ////////////////////////////////

   // Enable for st, ld, stu; slbi shares the prefix but skips memory
   assign dmem.enable = (opcode == mem_stage_pkg::op_st) ||
                        (opcode == mem_stage_pkg::op_ld) ||
                        (opcode == mem_stage_pkg::op_stu);
   // Only the two store forms write
   assign dmem.write = (opcode == mem_stage_pkg::op_st) ||
                       (opcode == mem_stage_pkg::op_stu);
   assign dmem.address = address;

   // Store source is rd field bits 7 to 5
   assign fwd_hit = wb_reg_wrt && (wb_rd == instruction[7:5]);
   // Writeback value wins over the stale operand
   assign dmem.write_data = fwd_hit ? wb_rd_data : rt_in;

   // Loads only, everything else passes zero
   assign read_data = (opcode == mem_stage_pkg::op_ld) ? dmem.read_data : '0;

   ////////////////////////////////
   // Destination register
   ////////////////////////////////

   always_comb begin
      if (opcode == mem_stage_pkg::op_slbi || opcode == mem_stage_pkg::op_lbi ||
          opcode == mem_stage_pkg::op_stu) begin
         dest_rd = instruction[10:8];
      end else if (opcode == mem_stage_pkg::op_jal || opcode == mem_stage_pkg::op_jalr) begin
         // Link register
         dest_rd = mem_stage_pkg::reg_idx_t'(7);
      end else if (opcode[4:3] == 2'b11) begin
         // Three register ALU forms
         dest_rd = instruction[4:2];
      end else begin
         dest_rd = instruction[7:5];
      end
   end

endmodule

// File: verilog/dmem_if.sv
// Data memory access interface with decoder and memory modports
interface dmem_if #(
   parameter int addr_bits = 8
);

   // Access controls from the decoder
   logic                 enable;
   logic                 write;
   mem_stage_pkg::word_t address;
   mem_stage_pkg::word_t write_data;
   // Gated read result back from the memory
   mem_stage_pkg::word_t read_data;

   // Word select, low address bits only
   logic [addr_bits-1:0] word_sel;
   assign word_sel = address[addr_bits-1:0];

   modport decoder (
      output enable, write, address, write_data,
      input  read_data
   );

   modport memory (
      input  enable, write, address, word_sel, write_data,
      output read_data
   );

endinterface

// File: verilog/mem_stage_pkg.sv
// Word, opcode, register index and dump state types with memory stage opcode constants
package mem_stage_pkg;

   ////////////////////////////////
   // Datapath types
   ////////////////////////////////

   // Data, address and instruction word
   typedef logic [15:0] word_t;

   // Instruction bits 15 to 11
   typedef logic [4:0] opcode_t;

   // Register file index
   typedef logic [2:0] reg_idx_t;

   // Dump sequencer states
   typedef enum logic [1:0] {
      idle,
      walk,
      finish
   } dump_state_t;

   ////////////////////////////////
   // Opcodes seen by this stage
   ////////////////////////////////

   // Memory operations share the 100 prefix
   localparam opcode_t op_st   = 5'b10000;
   localparam opcode_t op_ld   = 5'b10001;
   // Shift and load immediate, not a memory access
   localparam opcode_t op_slbi = 5'b10010;
   localparam opcode_t op_stu  = 5'b10011;
   localparam opcode_t op_lbi  = 5'b11000;
   // Jump and link forms write r7
   localparam opcode_t op_jal  = 5'b00110;
   localparam opcode_t op_jalr = 5'b00111;

endpackage
